// ==== source/ssr_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr constants
// widths, loop count, buffer depth and config map anchors of the lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SSR_CONSTS_SVH
`define SSR_CONSTS_SVH

// address pointer width, byte addresses
`define SSR_AW 16
// loop index and bound width
`define SSR_IW 16
// nested loops, fixed by the register map
`define SSR_NL 4
// data word width
`define SSR_DW 32
// entries in the data buffer
`define SSR_FIFO_DEPTH 4
// first alias word of the status register
`define SSR_ALIAS_BASE 24

`endif

// ==== source/ssr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr package
// types shared by the address generator, the lane and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "ssr_consts.svh"

package ssr_pkg;

  // memory byte address
  typedef logic [`SSR_AW-1:0] addr_t;

  // data word moved between memory and core
  typedef logic [`SSR_DW-1:0] data_t;

  // configuration word index, 32 words
  typedef logic [4:0] cfg_word_t;

  // loop index and loop bound
  typedef logic [`SSR_IW-1:0] index_t;

endpackage

`default_nettype wire

// ==== source/ssr_data_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr data buffer
// small circular buffer of data words with level count and flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "ssr_consts.svh"

module ssr_data_fifo (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           flush_i,
  input  logic           push_i,
  input  ssr_pkg::data_t wdata_i,
  input  logic           pop_i,
  output ssr_pkg::data_t rdata_o,
  output logic           empty_o,
  output logic           full_o,
  output logic [2:0]     level_o
);
  import ssr_pkg::*;

  localparam int DEPTH = `SSR_FIFO_DEPTH;
  localparam int PW = $clog2(DEPTH);

  // storage, no reset on payload
  data_t         mem_q [DEPTH];
  logic [PW-1:0] wptr_q, rptr_q;
  logic [2:0]    level_q;

  assign rdata_o = mem_q[rptr_q];
  assign empty_o = (level_q == 3'd0);
  assign full_o  = (level_q == 3'(DEPTH));
  assign level_o = level_q;

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) mem_q[wptr_q] <= wdata_i;
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (push_i) wptr_q <= wptr_q + PW'(1);
      if (pop_i)  rptr_q <= rptr_q + PW'(1);
      level_q <= level_q + 3'(push_i) - 3'(pop_i);
    end
  end

  // callers must respect full and empty
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== source/ssr_addr_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr address generator
// config register file with staged shadow copies and four nested
// loop counters that walk the address pattern of one job
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "ssr_consts.svh"

module ssr_addr_gen (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ssr_pkg::cfg_word_t cfg_word_i,
  input  logic [31:0]        cfg_wdata_i,
  input  logic               cfg_write_i,
  input  logic               ag_ready_i,
  output logic [31:0]        cfg_rdata_o,
  output logic [3:0]         reg_rep_o,
  output ssr_pkg::addr_t     ag_addr_o,
  output logic               ag_write_o,
  output logic               ag_valid_o
);
  import ssr_pkg::*;

  localparam int NL = `SSR_NL;
  localparam int DIMW = $clog2(`SSR_NL);

  // live registers used by the running job
  addr_t  [NL-1:0] stride_q;
  index_t [NL-1:0] bound_q;
  index_t [NL-1:0] index_q;
  logic   [3:0]    rep_q;
  addr_t           pointer_q;
  logic            done_q;
  logic            write_q;
  logic [DIMW-1:0] dims_q;

  // shadow copies, written any time, loaded into live when done
  addr_t  [NL-1:0] stride_sq, stride_sd;
  index_t [NL-1:0] bound_sq, bound_sd;
  logic   [3:0]    rep_sq, rep_sd;
  addr_t           pointer_sq, pointer_sd;
  logic            done_sq, done_sd;
  logic            write_sq, write_sd;
  logic [DIMW-1:0] dims_sq, dims_sd;

  // per-register write strobes
  logic [NL-1:0] stride_we;
  logic [NL-1:0] bound_we;
  logic          rep_we;
  logic          status_we;
  logic          alias_we;

  logic [NL-1:0] loop_en;
  logic [NL-1:0] loop_last;
  logic          last_beat;
  logic          beat;
  addr_t         sel_stride;
  addr_t         wdata_ptr;
  logic [31:0]   status_word;

  assign ag_valid_o = ~done_q;
  assign ag_write_o = write_q;
  assign ag_addr_o  = pointer_q;
  assign reg_rep_o  = rep_q;
  assign beat       = ag_valid_o & ag_ready_i;

  // pointers are word aligned, low two bits dropped
  assign wdata_ptr = cfg_wdata_i[`SSR_AW-1:0] & ~addr_t'(3);

  // word decode: strides, bounds, repeat, status, then the alias range
  always_comb begin
    for (int i = 0; i < NL; i++) begin
      stride_we[i] = cfg_write_i && (cfg_word_i == cfg_word_t'(i));
      bound_we[i]  = cfg_write_i && (cfg_word_i == cfg_word_t'(NL + i));
    end
    rep_we    = cfg_write_i && (cfg_word_i == cfg_word_t'(2 * NL));
    status_we = cfg_write_i && (cfg_word_i == cfg_word_t'(2 * NL + 1));
    alias_we  = cfg_write_i && (cfg_word_i >= cfg_word_t'(`SSR_ALIAS_BASE));
  end

  // next shadow state
  always_comb begin
    stride_sd  = stride_sq;
    bound_sd   = bound_sq;
    rep_sd     = rep_sq;
    pointer_sd = pointer_sq;
    done_sd    = done_sq;
    write_sd   = write_sq;
    dims_sd    = dims_sq;
    for (int i = 0; i < NL; i++) begin
      if (stride_we[i]) stride_sd[i] = wdata_ptr;
      if (bound_we[i])  bound_sd[i]  = cfg_wdata_i[`SSR_IW-1:0];
    end
    if (rep_we) rep_sd = cfg_wdata_i[3:0];
    if (status_we) begin
      pointer_sd = wdata_ptr;
      done_sd    = cfg_wdata_i[31];
      write_sd   = cfg_wdata_i[30];
      dims_sd    = cfg_wdata_i[29-:DIMW];
    end else if (alias_we) begin
      // alias word index carries write and dims, data is the start pointer
      pointer_sd = wdata_ptr;
      done_sd    = 1'b0;
      write_sd   = cfg_word_i[DIMW];
      dims_sd    = cfg_word_i[DIMW-1:0];
    end
  end

  // loop i wraps at its bound, loops above dims always count as wrapped
  for (genvar i = 0; i < NL; i++) begin : g_last
    assign loop_last[i] = (index_q[i] == bound_q[i]) || (int'(dims_q) < i);
  end

  // a loop steps only when every inner loop wraps
  always_comb begin
    logic carry;
    carry = 1'b1;
    for (int i = 0; i < NL; i++) begin
      loop_en[i] = carry;
      carry      = carry & loop_last[i];
    end
    last_beat = carry;
  end

  // outermost stepping loop picks the stride
  always_comb begin
    sel_stride = '0;
    for (int i = 0; i < NL; i++) begin
      if (loop_en[i]) sel_stride = stride_q[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stride_sq  <= '0;
      bound_sq   <= '0;
      rep_sq     <= '0;
      pointer_sq <= '0;
      done_sq    <= 1'b1;
      write_sq   <= 1'b0;
      dims_sq    <= '0;
    end else begin
      stride_sq  <= stride_sd;
      bound_sq   <= bound_sd;
      rep_sq     <= rep_sd;
      pointer_sq <= pointer_sd;
      done_sq    <= done_sd;
      write_sq   <= write_sd;
      dims_sq    <= dims_sd;
      // staged job handed over, do not start it twice
      if (done_q) done_sq <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stride_q  <= '0;
      bound_q   <= '0;
      rep_q     <= '0;
      pointer_q <= '0;
      done_q    <= 1'b1;
      write_q   <= 1'b0;
      dims_q    <= '0;
      index_q   <= '0;
    end else if (done_q) begin
      // idle: live registers follow the shadow, a pending start goes now
      stride_q  <= stride_sd;
      bound_q   <= bound_sd;
      rep_q     <= rep_sd;
      pointer_q <= pointer_sd;
      done_q    <= done_sd;
      write_q   <= write_sd;
      dims_q    <= dims_sd;
      index_q   <= '0;
    end else if (beat) begin
      pointer_q <= pointer_q + sel_stride;
      done_q    <= last_beat;
      for (int i = 0; i < NL; i++) begin
        if (loop_en[i]) index_q[i] <= loop_last[i] ? '0 : index_q[i] + index_t'(1);
      end
    end
  end

  // status: done, write, dims on top, pointer in the low bits
  always_comb begin
    status_word              = 32'(pointer_q);
    status_word[31]          = done_q;
    status_word[30]          = write_q;
    status_word[29-:DIMW]    = dims_q;
  end

  // combinational read of the live registers, aliases read as status
  always_comb begin
    cfg_rdata_o = '0;
    for (int i = 0; i < NL; i++) begin
      if (cfg_word_i == cfg_word_t'(i))      cfg_rdata_o = 32'(stride_q[i]);
      if (cfg_word_i == cfg_word_t'(NL + i)) cfg_rdata_o = 32'(bound_q[i]);
    end
    if (cfg_word_i == cfg_word_t'(2 * NL))      cfg_rdata_o = 32'(rep_q);
    if (cfg_word_i == cfg_word_t'(2 * NL + 1))  cfg_rdata_o = status_word;
    if (cfg_word_i >= cfg_word_t'(`SSR_ALIAS_BASE)) cfg_rdata_o = status_word;
  end

  // a stalled beat keeps its address and stays offered
  a_hold_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ag_valid_o && !ag_ready_i |=> ag_valid_o && $stable(ag_addr_o));

  // stride and start masking keep every beat word aligned
  a_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ag_valid_o |-> ag_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== source/ssr_lane.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr lane
// routes address beats to memory, prefetches read data with credits,
// repeats each read word and buffers core writes toward memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "ssr_consts.svh"

module ssr_lane (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           ag_valid_i,
  input  ssr_pkg::addr_t ag_addr_i,
  input  logic           ag_write_i,
  input  logic [3:0]     reg_rep_i,
  input  logic           reg_read_i,
  input  logic           reg_write_i,
  input  ssr_pkg::data_t reg_wdata_i,
  input  logic           mem_ready_i,
  input  logic           mem_rvalid_i,
  input  ssr_pkg::data_t mem_rdata_i,
  output logic           ag_ready_o,
  output ssr_pkg::data_t reg_rdata_o,
  output logic           reg_rvalid_o,
  output logic           reg_wready_o,
  output logic           mem_valid_o,
  output ssr_pkg::addr_t mem_addr_o,
  output logic           mem_write_o,
  output ssr_pkg::data_t mem_wdata_o
);
  import ssr_pkg::*;

  localparam int DEPTH = `SSR_FIFO_DEPTH;

  logic       ag_valid_q;
  logic       flush;
  logic       space;
  logic       can_issue;
  logic       accept;
  logic [2:0] outst_q;
  logic [3:0] rep_cnt_q;
  logic       rep_last;

  logic       fifo_push;
  logic       fifo_pop;
  logic       fifo_empty;
  logic       fifo_full;
  logic [2:0] fifo_level;
  data_t      fifo_wdata;
  data_t      fifo_rdata;

  // a new job starts on the rising edge of the beat valid
  assign flush = ag_valid_i & ~ag_valid_q;

  // read credits: buffered plus in-flight words never exceed depth
  assign space = ({1'b0, fifo_level} + {1'b0, outst_q}) < 4'(DEPTH);

  // write beats need a buffered word, read beats need a credit
  assign can_issue = ag_write_i ? ~fifo_empty : space;

  // no beat in the flush cycle, the buffer still holds the old job
  assign mem_valid_o = ag_valid_i & ~flush & can_issue;
  assign ag_ready_o  = ~flush & can_issue & mem_ready_i;
  assign accept      = ag_valid_i & ag_ready_o;

  assign mem_addr_o  = ag_addr_i;
  assign mem_write_o = ag_write_i;
  assign mem_wdata_o = fifo_rdata;

  // head word is popped on its last use
  assign rep_last = (rep_cnt_q == reg_rep_i);

  // buffer routing by direction
  assign fifo_push  = ag_write_i ? reg_write_i : mem_rvalid_i;
  assign fifo_wdata = ag_write_i ? reg_wdata_i : mem_rdata_i;
  assign fifo_pop   = ag_write_i ? accept : (reg_read_i & rep_last);

  // core side levels
  assign reg_rdata_o  = fifo_rdata;
  assign reg_rvalid_o = ~ag_write_i & ~fifo_empty;
  assign reg_wready_o = ag_write_i & ag_valid_i & ~flush & ~fifo_full;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ag_valid_q <= 1'b0;
    end else begin
      ag_valid_q <= ag_valid_i;
    end
  end

  // outstanding reads, up on a read beat and down on each response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else begin
      outst_q <= outst_q + 3'(accept & ~ag_write_i) - 3'(mem_rvalid_i);
    end
  end

  // repetition count of the head word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rep_cnt_q <= '0;
    end else if (flush) begin
      rep_cnt_q <= '0;
    end else if (reg_read_i) begin
      rep_cnt_q <= rep_last ? 4'd0 : rep_cnt_q + 4'd1;
    end
  end

  ssr_data_fifo i_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush),
    .push_i  (fifo_push),
    .wdata_i (fifo_wdata),
    .pop_i   (fifo_pop),
    .rdata_o (fifo_rdata),
    .empty_o (fifo_empty),
    .full_o  (fifo_full),
    .level_o (fifo_level)
  );

  // the core reads only what is on offer
  a_read_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_read_i |-> reg_rvalid_o);

  // memory answers only reads that were issued
  a_resp_credit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> outst_q != 3'd0);

endmodule

`default_nettype wire

// ==== source/ssr_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr top
// one data mover lane: address generator joined to the lane logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module ssr_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // config port
  input  ssr_pkg::cfg_word_t cfg_word_i,
  input  logic [31:0]        cfg_wdata_i,
  input  logic               cfg_write_i,
  output logic [31:0]        cfg_rdata_o,
  // core port
  output logic               reg_rvalid_o,
  output ssr_pkg::data_t     reg_rdata_o,
  input  logic               reg_read_i,
  output logic               reg_wready_o,
  input  logic               reg_write_i,
  input  ssr_pkg::data_t     reg_wdata_i,
  // memory port
  output logic               mem_valid_o,
  output ssr_pkg::addr_t     mem_addr_o,
  output logic               mem_write_o,
  output ssr_pkg::data_t     mem_wdata_o,
  input  logic               mem_ready_i,
  input  logic               mem_rvalid_i,
  input  ssr_pkg::data_t     mem_rdata_i
);
  import ssr_pkg::*;

  // beat handshake between generator and lane
  logic       ag_valid;
  logic       ag_ready;
  logic       ag_write;
  addr_t      ag_addr;
  logic [3:0] reg_rep;

  ssr_addr_gen i_addr_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_word_i  (cfg_word_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_write_i (cfg_write_i),
    .ag_ready_i  (ag_ready),
    .cfg_rdata_o (cfg_rdata_o),
    .reg_rep_o   (reg_rep),
    .ag_addr_o   (ag_addr),
    .ag_write_o  (ag_write),
    .ag_valid_o  (ag_valid)
  );

  ssr_lane i_lane (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ag_valid_i   (ag_valid),
    .ag_addr_i    (ag_addr),
    .ag_write_i   (ag_write),
    .reg_rep_i    (reg_rep),
    .reg_read_i   (reg_read_i),
    .reg_write_i  (reg_write_i),
    .reg_wdata_i  (reg_wdata_i),
    .mem_ready_i  (mem_ready_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .ag_ready_o   (ag_ready),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .reg_wready_o (reg_wready_o),
    .mem_valid_o  (mem_valid_o),
    .mem_addr_o   (mem_addr_o),
    .mem_write_o  (mem_write_o),
    .mem_wdata_o  (mem_wdata_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_ssr_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr memory model
// behavioral memory with random acceptance, in-order one-cycle read
// responses and a log of every write it takes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module tb_ssr_mem (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           mem_valid_i,
  input  ssr_pkg::addr_t mem_addr_i,
  input  logic           mem_write_i,
  input  ssr_pkg::data_t mem_wdata_i,
  output logic           mem_ready_o,
  output logic           mem_rvalid_o,
  output ssr_pkg::data_t mem_rdata_o
);
  import ssr_pkg::*;

  localparam int LOG_DEPTH = 64;

  // read taken on the last rising edge, answered on the falling edge
  logic  pend_q;
  data_t pend_data_q;

  // write log, read by the testbench in order
  addr_t wr_addr [LOG_DEPTH];
  data_t wr_data [LOG_DEPTH];
  int    wr_count;

  initial begin
    mem_ready_o  = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
  end

  // requests are taken on the rising edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      pend_data_q <= '0;
      wr_count    <= 0;
    end else begin
      pend_q <= mem_valid_i && mem_ready_o && !mem_write_i;
      // a word reads as its address in both halves
      pend_data_q <= {mem_addr_i, mem_addr_i};
      if (mem_valid_i && mem_ready_o && mem_write_i) begin
        wr_addr[wr_count] <= mem_addr_i;
        wr_data[wr_count] <= mem_wdata_i;
        wr_count          <= wr_count + 1;
      end
    end
  end

  // response strobe and acceptance pattern move on the falling edge
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_ready_o  <= 1'b0;
      mem_rvalid_o <= 1'b0;
      mem_rdata_o  <= '0;
    end else begin
      mem_rvalid_o <= pend_q;
      mem_rdata_o  <= pend_data_q;
      // roughly one stall in four
      mem_ready_o  <= ($urandom % 4) != 0;
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_ssr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ssr testbench
// directed tests of the lane covering register access, read streams in
// one and four dimensions, repetition, write stream and config staging
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "ssr_consts.svh"

module tb_ssr;
  import ssr_pkg::*;

  localparam int unsigned SEED = 32'h605c69e4;
  // beats of all jobs below size the watchdog
  localparam int TOTAL_BEATS = 8 + 24 + 4 + 6 + 12;
  localparam int CYCLES_PER_BEAT = 40;

  logic        clk_i;
  logic        rst_ni;
  cfg_word_t   cfg_word_i;
  logic [31:0] cfg_wdata_i;
  logic        cfg_write_i;
  logic [31:0] cfg_rdata_o;
  logic        reg_rvalid_o;
  data_t       reg_rdata_o;
  logic        reg_read_i;
  logic        reg_wready_o;
  logic        reg_write_i;
  data_t       reg_wdata_i;
  logic        mem_valid_o;
  addr_t       mem_addr_o;
  logic        mem_write_o;
  data_t       mem_wdata_o;
  logic        mem_ready_i;
  logic        mem_rvalid_i;
  data_t       mem_rdata_i;

  // job settings as the testbench sees them
  addr_t      stride_cfg [`SSR_NL];
  index_t     bound_cfg [`SSR_NL];
  int         dims_cfg;
  logic [3:0] rep_cfg;
  addr_t      exp_addr [64];
  int         exp_count;

  int checks;
  int errors;
  int tests_run;
  int tests_bad;
  int test_err_start;

  ssr_top dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_word_i   (cfg_word_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_write_i  (cfg_write_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .reg_rdata_o  (reg_rdata_o),
    .reg_read_i   (reg_read_i),
    .reg_wready_o (reg_wready_o),
    .reg_write_i  (reg_write_i),
    .reg_wdata_i  (reg_wdata_i),
    .mem_valid_o  (mem_valid_o),
    .mem_addr_o   (mem_addr_o),
    .mem_write_o  (mem_write_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ready_i  (mem_ready_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  tb_ssr_mem mem0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_valid_i  (mem_valid_o),
    .mem_addr_i   (mem_addr_o),
    .mem_write_i  (mem_write_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_ready_o  (mem_ready_i),
    .mem_rvalid_o (mem_rvalid_i),
    .mem_rdata_o  (mem_rdata_i)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("%-22s ok", name);
    end else begin
      tests_bad++;
      $display("%-22s %0d mismatches", name, errors - test_err_start);
    end
  endtask

  // one-cycle write strobe on the config port
  task automatic cfg_write(input cfg_word_t w, input logic [31:0] d);
    cfg_word_i  = w;
    cfg_wdata_i = d;
    cfg_write_i = 1'b1;
    @(negedge clk_i);
    cfg_write_i = 1'b0;
  endtask

  // read port is combinational, sampled just after the word changes
  task automatic cfg_read(input cfg_word_t w, output logic [31:0] d);
    cfg_word_i = w;
    #1;
    d = cfg_rdata_o;
    @(negedge clk_i);
  endtask

  task automatic configure(input addr_t s0, input addr_t s1, input addr_t s2,
                           input addr_t s3, input index_t b0, input index_t b1,
                           input index_t b2, input index_t b3, input int dims,
                           input logic [3:0] rep);
    stride_cfg = '{s0, s1, s2, s3};
    bound_cfg  = '{b0, b1, b2, b3};
    dims_cfg   = dims;
    rep_cfg    = rep;
    for (int i = 0; i < `SSR_NL; i++) begin
      cfg_write(cfg_word_t'(i), 32'(stride_cfg[i]));
      cfg_write(cfg_word_t'(`SSR_NL + i), 32'(bound_cfg[i]));
    end
    cfg_write(cfg_word_t'(8), 32'(rep_cfg));
  endtask

  // alias word carries write in bit 2 and dims below
  task automatic start_job(input addr_t start, input logic wr);
    cfg_write(cfg_word_t'(`SSR_ALIAS_BASE + (wr ? 4 : 0) + dims_cfg), 32'(start));
  endtask

  // innermost loop runs first and the first loop short of its bound steps
  task automatic gen_addresses(input addr_t start);
    index_t idx [`SSR_NL];
    addr_t  ptr;
    int     k;
    int     total;
    ptr   = start;
    total = 1;
    for (int i = 0; i < `SSR_NL; i++) idx[i] = '0;
    for (int i = 0; i <= dims_cfg; i++) total *= int'(bound_cfg[i]) + 1;
    exp_count = total;
    for (int n = 0; n < total; n++) begin
      exp_addr[n] = ptr;
      k = 0;
      while (k <= dims_cfg && idx[k] == bound_cfg[k]) k++;
      if (k <= dims_cfg) begin
        ptr = ptr + stride_cfg[k];
        for (int j = 0; j < k; j++) idx[j] = '0;
        idx[k] = idx[k] + 1;
      end
    end
  endtask

  task automatic read_word(output data_t d);
    while (!reg_rvalid_o) @(negedge clk_i);
    d          = reg_rdata_o;
    reg_read_i = 1'b1;
    @(negedge clk_i);
    reg_read_i = 1'b0;
  endtask

  task automatic write_word(input data_t d);
    while (!reg_wready_o) @(negedge clk_i);
    reg_wdata_i = d;
    reg_write_i = 1'b1;
    @(negedge clk_i);
    reg_write_i = 1'b0;
  endtask

  // every expected word rep+1 times and then nothing left on offer
  task automatic read_stream(input bit gaps);
    data_t d;
    for (int n = 0; n < exp_count; n++) begin
      for (int r = 0; r <= int'(rep_cfg); r++) begin
        if (gaps) repeat ($urandom % 3) @(negedge clk_i);
        read_word(d);
        check_data(d, {exp_addr[n], exp_addr[n]}, $sformatf("word %0d use %0d", n, r));
      end
    end
    check_word(32'(reg_rvalid_o), 32'h0, "word left after stream");
  endtask

  task automatic check_done(input logic wr);
    logic [31:0] st;
    cfg_read(cfg_word_t'(9), st);
    check_word(st & 32'hF000_0000, {1'b1, wr, 2'(dims_cfg), 28'h0}, "status after job");
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    logic [31:0] v;
    test_err_start = errors;
    // no job yet, so no request and nothing offered to the core
    check_word(32'({mem_valid_o, reg_rvalid_o, reg_wready_o}), 32'h0,
               "memory and core levels after reset");
    cfg_read(cfg_word_t'(9), rd);
    check_word(rd & 32'h8000_0000, 32'h8000_0000, "status done after reset");
    for (int i = 0; i < `SSR_NL; i++) begin
      v = 32'hFFFF_1235 + 32'(i) * 32'h0000_0111;
      cfg_write(cfg_word_t'(i), v);
      cfg_read(cfg_word_t'(i), rd);
      check_word(rd, v & 32'h0000_FFFC, $sformatf("stride %0d", i));
      v = 32'hABCD_0042 + 32'(i) * 32'h0000_1357;
      cfg_write(cfg_word_t'(`SSR_NL + i), v);
      cfg_read(cfg_word_t'(`SSR_NL + i), rd);
      check_word(rd, v & 32'h0000_FFFF, $sformatf("bound %0d", i));
    end
    cfg_write(cfg_word_t'(8), 32'hFFFF_FFF5);
    cfg_read(cfg_word_t'(8), rd);
    check_word(rd, 32'h5, "repeat");
    end_test("register access");
  endtask

  task automatic test_read_1d();
    test_err_start = errors;
    configure(16'h4, 16'h0, 16'h0, 16'h0, 16'd7, 16'd0, 16'd0, 16'd0, 0, 4'd0);
    gen_addresses(16'h0100);
    start_job(16'h0100, 1'b0);
    read_stream(1'b0);
    check_done(1'b0);
    end_test("read stream 1d");
  endtask

  task automatic test_read_4d();
    test_err_start = errors;
    configure(16'h8, 16'h20, 16'h7C, 16'h204, 16'd1, 16'd2, 16'd1, 16'd1, 3, 4'd0);
    gen_addresses(16'h1000);
    start_job(16'h1000, 1'b0);
    read_stream(1'b1);
    check_done(1'b0);
    end_test("read stream 4d");
  endtask

  task automatic test_repeat();
    test_err_start = errors;
    configure(16'h4, 16'h0, 16'h0, 16'h0, 16'd3, 16'd0, 16'd0, 16'd0, 0, 4'd2);
    gen_addresses(16'h0200);
    start_job(16'h0200, 1'b0);
    read_stream(1'b0);
    check_done(1'b0);
    end_test("repetition");
  endtask

  task automatic test_write();
    int base;
    test_err_start = errors;
    configure(16'h8, 16'h0, 16'h0, 16'h0, 16'd5, 16'd0, 16'd0, 16'd0, 0, 4'd0);
    gen_addresses(16'h2000);
    base = mem0.wr_count;
    start_job(16'h2000, 1'b1);
    for (int n = 0; n < exp_count; n++) write_word(32'hA500_0000 | 32'(n));
    // memory log catches up once the buffer drains
    while (mem0.wr_count < base + exp_count) @(negedge clk_i);
    for (int n = 0; n < exp_count; n++) begin
      check_addr(mem0.wr_addr[base + n], exp_addr[n], $sformatf("write addr %0d", n));
      check_data(mem0.wr_data[base + n], 32'hA500_0000 | 32'(n),
                 $sformatf("write data %0d", n));
    end
    check_done(1'b1);
    end_test("write stream");
  endtask

  task automatic test_staging();
    logic [31:0] rd;
    test_err_start = errors;
    configure(16'h4, 16'h0, 16'h0, 16'h0, 16'd7, 16'd0, 16'd0, 16'd0, 0, 4'd0);
    gen_addresses(16'h0300);
    start_job(16'h0300, 1'b0);
    // job stalls on credits until the core reads so it is still running
    stride_cfg[0] = 16'h10;
    bound_cfg[0]  = 16'd3;
    cfg_write(cfg_word_t'(0), 32'h10);
    cfg_write(cfg_word_t'(`SSR_NL), 32'd3);
    cfg_read(cfg_word_t'(0), rd);
    check_word(rd, 32'h4, "live stride during job");
    read_stream(1'b0);
    check_done(1'b0);
    // staged stride and bound apply from this start on
    gen_addresses(16'h0400);
    start_job(16'h0400, 1'b0);
    read_stream(1'b0);
    check_done(1'b0);
    end_test("config staging");
  endtask

  initial begin : watchdog
    repeat (TOTAL_BEATS * CYCLES_PER_BEAT) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d clock cycles",
             TOTAL_BEATS * CYCLES_PER_BEAT);
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst_ni      = 1'b0;
    cfg_word_i  = '0;
    cfg_wdata_i = '0;
    cfg_write_i = 1'b0;
    reg_read_i  = 1'b0;
    reg_write_i = 1'b0;
    reg_wdata_i = '0;
    checks      = 0;
    errors      = 0;
    tests_run   = 0;
    tests_bad   = 0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_registers();
    test_read_1d();
    test_read_4d();
    test_repeat();
    test_write();
    test_staging();
    $display("summary: %0d tests, %0d clean, %0d with errors, %0d mismatches in %0d checks",
             tests_run, tests_run - tests_bad, tests_bad, errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/ssr_pkg.sv
source/ssr_data_fifo.sv
source/ssr_addr_gen.sv
source/ssr_lane.sv
source/ssr_top.sv
bench/tb_ssr_mem.sv
bench/tb_ssr.sv
